//--- verif/spi_input.txt
// mode bits: 1 cpol, 2 cpha, 3 lsb first, 4 irq enable (core enable added on top)
// columns: mode divisor slave_select tx_byte reply_byte, all hex
00 0000 01 a5 3c
12 0001 02 5a c3
04 0002 04 81 7e
16 0003 08 01 80
08 0001 10 c4 2b
1a 0000 20 96 69
0c 0004 40 7f fe
1e 0002 80 e1 1e
10 0102 01 33 cc
06 0007 02 0f f0

//--- list.f
verilog/spi_pkg.sv
verilog/spi_wb_regs.sv
verilog/spi_baud_gen.sv
verilog/spi_shift_engine.sv
verilog/spi_master_top.sv
verif/tb_spi_master.sv

//--- Makefile
# verilator build and run of the spi master testbench

VERILATOR ?= verilator
TOP       ?= tb_spi_master
FLAGS     ?= -j 0
OBJ_DIR   ?= obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) --binary $(FLAGS) --timescale 1ns/100ps --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f list.f

# status comes from the search for the pass line
run: compile
	@out="$$(./$(BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf $(OBJ_DIR)

//--- verif/tb_spi_master.sv
// testbench for the wishbone spi master, file driven transfers against a spi slave model
`timescale 1ns/100ps

module tb_spi_master;

	import spi_pkg::*;

	localparam int DIV_W  = 16;
	localparam int NUM_SS = 8;

	logic              wb_clk_i;
	logic              rst;
	spi_reg_e          wb_adr_i;
	logic [7:0]        wb_dat_i;
	logic [7:0]        wb_dat_o;
	logic              wb_we_i;
	logic              wb_stb_i;
	logic              wb_cyc_i;
	logic              wb_ack_o;
	logic              wb_inta_o;
	logic              spi_tip_o;
	logic              miso_i;
	logic              sclk_o;
	logic              mosi_o;
	logic [NUM_SS-1:0] ss_n_o;

	// one entry per data file line
	logic [7:0]  t_mode [$];
	logic [15:0] t_div [$];
	logic [7:0]  t_ss [$];
	logic [7:0]  t_tx [$];
	logic [7:0]  t_rep [$];

	// slave model setup, written by the main sequence
	logic              cur_cpol, cur_cpha, cur_lsb;
	logic [7:0]        cur_reply;
	logic [NUM_SS-1:0] cur_ss;
	int                cur_div;
	logic              slave_arm = 1'b0;
	// slave model state
	logic              slave_ready = 1'b0;
	logic [7:0]        slave_cap;   // byte seen on mosi
	int                send_cnt, cap_cnt, edge_cnt, last_edge;
	int                cycles = 0;
	int                cycle_limit = 0; // 0 until the file is read

	spi_master_top #(.DIV_W(DIV_W), .NUM_SS(NUM_SS)) uut (.*);

	initial begin
		wb_clk_i = 1'b0;
		forever #2 wb_clk_i = ~wb_clk_i;
	end

	// ----------------------------------------
	// timeout and checks
	// ----------------------------------------

	always @(posedge wb_clk_i) begin
		cycles = cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("timeout, the run went past %0d bus clock cycles", cycle_limit);
			stop_run();
		end
	end

	task automatic stop_run();
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
		if (got !== exp) begin
			$display("[ERROR] %0t ns %s: got %02h, expected %02h", $time, what, got, exp);
			stop_run();
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("[ERROR] %0t ns %s: got %b, expected %b", $time, what, got, exp);
			stop_run();
		end
	endtask

	task automatic check_ss(input logic [NUM_SS-1:0] got, input logic [NUM_SS-1:0] exp,
			input string what);
		if (got !== exp) begin
			$display("[ERROR] %0t ns %s: got %b, expected %b", $time, what, got, exp);
			stop_run();
		end
	endtask

	task automatic check_count(input int got, input int exp, input string what);
		if (got != exp) begin
			$display("[ERROR] %0t ns %s: got %0d, expected %0d", $time, what, got, exp);
			stop_run();
		end
	endtask

	// single classic cycle, returns read data from the ack cycle
	task automatic wb_access(input logic we, input spi_reg_e adr, input logic [7:0] dat,
			output logic [7:0] rdat);
		@(posedge wb_clk_i);
		#1;
		wb_adr_i = adr;
		wb_dat_i = dat;
		wb_we_i  = we;
		wb_cyc_i = 1'b1;
		wb_stb_i = 1'b1;
		do
			@(negedge wb_clk_i);
		while (!wb_ack_o);
		rdat = wb_dat_o;
		@(posedge wb_clk_i); // write lands on this edge
		#1;
		check_bit(wb_ack_o, 1'b0, "ack held past one cycle");
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i  = 1'b0;
	endtask

	// ----------------------------------------
	// spi slave model
	// ----------------------------------------

	function automatic logic reply_bit(input logic [2:0] k);
		return cur_lsb ? cur_reply[k] : cur_reply[3'd7 - k];
	endfunction

	initial begin
		miso_i = 1'b0;
		forever begin
			@(sclk_o or slave_arm);
			if (slave_arm && !slave_ready) begin
				slave_ready = 1'b1;
				send_cnt    = 0;
				cap_cnt     = 0;
				edge_cnt    = 0;
				if (!cur_cpha) begin
					miso_i   = reply_bit(3'd0); // first bit out before any edge
					send_cnt = 1;
				end
			end else if (!slave_arm) begin
				slave_ready = 1'b0;
			end else if (ss_n_o !== '1) begin
				#1;
				check_ss(ss_n_o, ~cur_ss, "slave select during transfer");
				if (edge_cnt > 0)
					check_count(cycles - last_edge, cur_div + 1, "sclk half period");
				last_edge = cycles;
				edge_cnt++;
				// leading edge samples for cpha 0, trailing for cpha 1
				if ((sclk_o != cur_cpol) ^ cur_cpha) begin
					slave_cap[cur_lsb ? 3'(cap_cnt) : 3'd7 - 3'(cap_cnt)] = mosi_o;
					cap_cnt++;
				end else if (send_cnt < 8) begin
					miso_i = reply_bit(3'(send_cnt));
					send_cnt++;
				end
			end
		end
	end

	// ----------------------------------------
	// main sequence
	// ----------------------------------------

	initial begin
		logic [7:0]  rd, mode, ss, tx, rp;
		logic [15:0] dv;
		int          fd;
		int          max_div;
		string       line;
		rst      = 1'b1;
		wb_adr_i = REG_CTRL;
		wb_dat_i = 8'h00;
		wb_we_i  = 1'b0;
		wb_stb_i = 1'b0;
		wb_cyc_i = 1'b0;
		void'($urandom(90));
		max_div = 0;
		fd = $fopen("verif/spi_input.txt", "r");
		if (fd == 0) begin
			$display("could not open the stimulus file verif/spi_input.txt");
			stop_run();
		end
		while ($fgets(line, fd) != 0) begin
			if (line.len() > 2 && line.substr(0, 1) != "//" &&
					$sscanf(line, "%h %h %h %h %h", mode, dv, ss, tx, rp) == 5) begin
				t_mode.push_back(mode);
				t_div.push_back(dv);
				t_ss.push_back(ss);
				t_tx.push_back(tx);
				t_rep.push_back(rp);
				if (int'(dv) > max_div)
					max_div = int'(dv);
			end
		end
		$fclose(fd);
		cycle_limit = t_tx.size() * (16 * (max_div + 1) + 100);

		repeat (2) @(posedge wb_clk_i);
		#1;
		rst = 1'b0;
		check_ss(ss_n_o, '1, "slave select after reset");
		check_bit(sclk_o, 1'b0, "sclk after reset");
		check_bit(mosi_o, 1'b0, "mosi after reset");
		check_bit(wb_inta_o, 1'b0, "interrupt after reset");
		check_bit(spi_tip_o, 1'b0, "tip after reset");
		wb_access(1'b0, REG_CTRL, 8'h00, rd);
		check_byte(rd, 8'h00, "control after reset");
		wb_access(1'b0, REG_STAT, 8'h00, rd);
		check_byte(rd, 8'h00, "status after reset");

		for (int i = 0; i < t_tx.size(); i++) begin
			wb_access(1'b1, REG_CTRL, t_mode[i] | (8'd1 << CTRL_SPE), rd);
			wb_access(1'b1, REG_DIVL, t_div[i][7:0], rd);
			wb_access(1'b1, REG_DIVH, t_div[i][15:8], rd);
			wb_access(1'b1, REG_SS, t_ss[i], rd);
			cur_cpol  = t_mode[i][CTRL_CPOL];
			cur_cpha  = t_mode[i][CTRL_CPHA];
			cur_lsb   = t_mode[i][CTRL_LSBFE];
			cur_reply = t_rep[i];
			cur_ss    = NUM_SS'(t_ss[i]);
			cur_div   = int'(t_div[i]);
			slave_arm = 1'b1;
			wb_access(1'b1, REG_TXD, t_tx[i], rd);
			wait (spi_tip_o);
			#1;
			check_ss(ss_n_o, ~cur_ss, "slave select at start");
			// second write while busy is dropped
			wb_access(1'b1, REG_TXD, ~t_tx[i], rd);
			wb_access(1'b0, REG_TXD, 8'h00, rd);
			check_byte(rd, t_tx[i], "transmit byte kept while busy");
			do
				wb_access(1'b0, REG_STAT, 8'h00, rd);
			while (rd[STAT_TIP]);
			check_bit(rd[STAT_DONE], 1'b1, "done flag at end");
			check_bit(wb_inta_o, t_mode[i][CTRL_IE], "interrupt at end");
			check_bit(sclk_o, cur_cpol, "sclk idle level");
			check_ss(ss_n_o, '1, "slave select released");
			check_byte(slave_cap, t_tx[i], "byte seen by slave");
			check_count(edge_cnt, 16, "sclk edges per byte");
			wb_access(1'b0, REG_RXD, 8'h00, rd);
			check_byte(rd, t_rep[i], "received byte");
			wb_access(1'b1, REG_STAT, 8'd1 << STAT_DONE, rd); // write 1 clears
			wb_access(1'b0, REG_STAT, 8'h00, rd);
			check_bit(rd[STAT_DONE], 1'b0, "done flag cleared");
			check_bit(wb_inta_o, 1'b0, "interrupt cleared");
			slave_arm = 1'b0;
			repeat ($urandom % 8) @(posedge wb_clk_i);
		end

		// core disabled, transmit write must not start anything
		wb_access(1'b1, REG_CTRL, 8'h00, rd);
		wb_access(1'b1, REG_TXD, 8'h5a, rd);
		repeat (4) begin
			@(negedge wb_clk_i);
			check_bit(spi_tip_o, 1'b0, "tip with core disabled");
		end
		wb_access(1'b0, REG_STAT, 8'h00, rd);
		check_byte(rd, 8'h00, "status with core disabled");

		$display("All tests passed");
		$finish;
	end

endmodule

//--- verilog/spi_master_top.sv
// wishbone spi master top level, register block, baud generator and serial engine
`timescale 1ns/100ps

module spi_master_top #(
	parameter int DIV_W  = 16,
	parameter int NUM_SS = 8
) (
	input  logic              wb_clk_i,
	input  logic              rst,       // async, active high
	input  spi_pkg::spi_reg_e wb_adr_i,
	input  logic [7:0]        wb_dat_i,
	output logic [7:0]        wb_dat_o,
	input  logic              wb_we_i,
	input  logic              wb_stb_i,
	input  logic              wb_cyc_i,
	output logic              wb_ack_o,
	output logic              wb_inta_o,
	output logic              spi_tip_o,
	input  logic              miso_i,
	output logic              sclk_o,
	output logic              mosi_o,
	output logic [NUM_SS-1:0] ss_n_o
);

	// ----------------------------------------
	// internal nets
	// ----------------------------------------

	logic              start;
	logic              cpol;
	logic              cpha;
	logic              lsbfe;
	logic [DIV_W-1:0]  divisor;
	logic [7:0]        tx_data;
	logic [NUM_SS-1:0] ss_sel;
	logic              busy;
	logic              done;
	logic [7:0]        rx_data;
	logic              run;
	logic              tick;

	assign spi_tip_o = busy;

	// bus side
	spi_wb_regs #(.DIV_W(DIV_W), .NUM_SS(NUM_SS)) u_regs (
		.wb_clk_i(wb_clk_i), .rst(rst),
		.wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i), .wb_we_i(wb_we_i),
		.wb_stb_i(wb_stb_i), .wb_cyc_i(wb_cyc_i),
		.wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o), .wb_inta_o(wb_inta_o),
		.busy_i(busy), .done_i(done), .rx_data_i(rx_data),
		.start_o(start), .cpol_o(cpol), .cpha_o(cpha), .lsbfe_o(lsbfe),
		.divisor_o(divisor), .tx_data_o(tx_data), .ss_sel_o(ss_sel)
	);

	// sclk half-period strobe
	spi_baud_gen #(.DIV_W(DIV_W)) u_baud (
		.wb_clk_i(wb_clk_i), .rst(rst),
		.run_i(run), .divisor_i(divisor), .tick_o(tick)
	);

	// serial side and pins
	spi_shift_engine #(.NUM_SS(NUM_SS)) u_engine (
		.wb_clk_i(wb_clk_i), .rst(rst),
		.start_i(start), .tick_i(tick),
		.cpol_i(cpol), .cpha_i(cpha), .lsbfe_i(lsbfe),
		.tx_data_i(tx_data), .ss_sel_i(ss_sel), .miso_i(miso_i),
		.run_o(run), .busy_o(busy), .done_o(done), .rx_data_o(rx_data),
		.sclk_o(sclk_o), .mosi_o(mosi_o), .ss_n_o(ss_n_o)
	);

endmodule

//--- verilog/spi_shift_engine.sv
// spi serial engine, transfer fsm with shift register and registered pin drivers
`timescale 1ns/100ps

module spi_shift_engine #(
	parameter int NUM_SS = 8
) (
	input  logic              wb_clk_i,
	input  logic              rst,
	input  logic              start_i,   // one-cycle request from regs
	input  logic              tick_i,    // sclk half-period strobe
	input  logic              cpol_i,
	input  logic              cpha_i,
	input  logic              lsbfe_i,
	input  logic [7:0]        tx_data_i,
	input  logic [NUM_SS-1:0] ss_sel_i,  // one-hot
	input  logic              miso_i,
	output logic              run_o,
	output logic              busy_o,
	output logic              done_o,
	output logic [7:0]        rx_data_o,
	output logic              sclk_o,
	output logic              mosi_o,
	output logic [NUM_SS-1:0] ss_n_o
);

	import spi_pkg::*;

	spi_state_e        state_q;
	logic [7:0]        sr_q;       // tx bits out one end, rx bits in the other
	logic [7:0]        sr_shift;
	logic              out_bit;
	logic              first_bit;  // bit on mosi before the first edge
	logic [2:0]        bit_cnt_q;
	logic              sclk_q;
	logic              mosi_q;
	logic [NUM_SS-1:0] ss_n_q;

	// miso enters where the last tx bit left
	assign sr_shift  = lsbfe_i ? {miso_i, sr_q[7:1]} : {sr_q[6:0], miso_i};
	assign out_bit   = lsbfe_i ? sr_q[0] : sr_q[7];
	assign first_bit = lsbfe_i ? tx_data_i[0] : tx_data_i[7];

	// ----------------------------------------
	// transfer fsm and pin drivers
	// ----------------------------------------

	always_ff @(posedge wb_clk_i or posedge rst) begin
		if (rst) begin
			state_q   <= ST_IDLE;
			bit_cnt_q <= 3'd0;
			sclk_q    <= 1'b0;
			mosi_q    <= 1'b0;
			ss_n_q    <= '1; // all deselected
		end else begin
			case (state_q)
				ST_IDLE: begin
					sclk_q <= cpol_i; // idle level follows cpol
					if (start_i) begin
						state_q   <= ST_LEAD;
						bit_cnt_q <= 3'd0;
						ss_n_q    <= ~ss_sel_i;
						if (!cpha_i)
							mosi_q <= first_bit; // cpha 0 drives before first edge
					end
				end
				ST_LEAD: begin
					if (tick_i) begin
						sclk_q  <= ~cpol_i; // leading edge
						state_q <= ST_TRAIL;
						if (cpha_i)
							mosi_q <= out_bit; // cpha 1 drives on leading
					end
				end
				ST_TRAIL: begin
					if (tick_i) begin
						sclk_q    <= cpol_i; // trailing edge
						bit_cnt_q <= bit_cnt_q + 3'd1;
						// cpha 0 sampled on lead, next bit goes out now
						if (!cpha_i && bit_cnt_q != 3'd7)
							mosi_q <= out_bit;
						if (bit_cnt_q == 3'd7)
							state_q <= ST_DONE;
						else
							state_q <= ST_LEAD;
					end
				end
				ST_DONE: begin
					state_q <= ST_IDLE;
					ss_n_q  <= '1; // release after completion
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	// ----------------------------------------
	// shift register
	// ----------------------------------------

	// sample edge depends on cpha
	always_ff @(posedge wb_clk_i) begin
		if (state_q == ST_IDLE && start_i)
			sr_q <= tx_data_i;
		else if (tick_i && state_q == ST_LEAD && !cpha_i)
			sr_q <= sr_shift; // cpha 0 samples on leading
		else if (tick_i && state_q == ST_TRAIL && cpha_i)
			sr_q <= sr_shift; // cpha 1 samples on trailing
	end

	assign run_o     = (state_q == ST_LEAD) || (state_q == ST_TRAIL);
	assign busy_o    = (state_q != ST_IDLE);
	assign done_o    = (state_q == ST_DONE);
	assign rx_data_o = sr_q; // full byte by st_done
	assign sclk_o    = sclk_q;
	assign mosi_o    = mosi_q;
	assign ss_n_o    = ss_n_q;

endmodule

//--- verilog/spi_baud_gen.sv
// baud tick generator, one tick per sclk half-period while a transfer runs
`timescale 1ns/100ps

module spi_baud_gen #(
	parameter int DIV_W = 16
) (
	input  logic             wb_clk_i,
	input  logic             rst,
	input  logic             run_i,     // engine in lead or trail
	input  logic [DIV_W-1:0] divisor_i,
	output logic             tick_o     // half-period strobe
);

	logic [DIV_W-1:0] cnt_q;
	logic             cnt_zero;

	assign cnt_zero = (cnt_q == '0);

	// ----------------------------------------
	// down counter
	// ----------------------------------------

	// divisor+1 cycles per tick
	// counts divisor down to 0, then reloads
	always_ff @(posedge wb_clk_i or posedge rst) begin
		if (rst) begin
			cnt_q <= '0;
		end else if (!run_i) begin
			cnt_q <= divisor_i; // parked at reload so first half is full
		end else if (cnt_zero) begin
			cnt_q <= divisor_i;
		end else begin
			cnt_q <= cnt_q - 1'b1;
		end
	end

	// no ticks outside a transfer
	assign tick_o = run_i & cnt_zero;

endmodule

//--- verilog/spi_wb_regs.sv
// wishbone slave register file, builds start pulse, done flag and interrupt
`timescale 1ns/100ps

module spi_wb_regs #(
	parameter int DIV_W  = 16,
	parameter int NUM_SS = 8
) (
	input  logic              wb_clk_i,
	input  logic              rst,
	input  spi_pkg::spi_reg_e wb_adr_i,
	input  logic [7:0]        wb_dat_i,
	input  logic              wb_we_i,
	input  logic              wb_stb_i,
	input  logic              wb_cyc_i,
	output logic [7:0]        wb_dat_o,
	output logic              wb_ack_o,
	output logic              wb_inta_o,
	input  logic              busy_i,    // engine transfer in progress
	input  logic              done_i,    // one-cycle end of transfer
	input  logic [7:0]        rx_data_i,
	output logic              start_o,
	output logic              cpol_o,
	output logic              cpha_o,
	output logic              lsbfe_o,
	output logic [DIV_W-1:0]  divisor_o,
	output logic [7:0]        tx_data_o,
	output logic [NUM_SS-1:0] ss_sel_o
);

	import spi_pkg::*;

	logic              ack_q;
	logic              wr;      // write in its ack cycle
	logic              wr_txd;
	logic [4:0]        ctrl_q;  // upper three bits not stored
	logic [15:0]       div_q;
	logic [NUM_SS-1:0] ss_q;
	logic [7:0]        tx_q;
	logic [7:0]        rx_q;
	logic              done_q;  // sticky
	logic              start_q;
	logic [7:0]        stat_v;

	// ----------------------------------------
	// bus handshake
	// ----------------------------------------

	// one-cycle ack, never two in a row
	always_ff @(posedge wb_clk_i or posedge rst) begin
		if (rst)
			ack_q <= 1'b0;
		else
			ack_q <= wb_cyc_i & wb_stb_i & ~ack_q;
	end

	assign wr     = wb_cyc_i & wb_stb_i & ack_q & wb_we_i; // lands at end of ack
	assign wr_txd = wr & (wb_adr_i == REG_TXD);

	// ----------------------------------------
	// control state
	// ----------------------------------------

	always_ff @(posedge wb_clk_i or posedge rst) begin
		if (rst) begin
			ctrl_q  <= '0;
			div_q   <= '0;
			ss_q    <= '0;
			done_q  <= 1'b0;
			start_q <= 1'b0;
		end else begin
			if (wr && wb_adr_i == REG_CTRL)
				ctrl_q <= wb_dat_i[4:0];
			if (wr && wb_adr_i == REG_DIVL)
				div_q[7:0] <= wb_dat_i;
			if (wr && wb_adr_i == REG_DIVH)
				div_q[15:8] <= wb_dat_i;
			if (wr && wb_adr_i == REG_SS)
				ss_q <= NUM_SS'(wb_dat_i);
			// set beats clear in the same cycle
			if (done_i)
				done_q <= 1'b1;
			else if (wr && wb_adr_i == REG_STAT && wb_dat_i[STAT_DONE])
				done_q <= 1'b0;
			// only when enabled and idle, else the write is dropped
			start_q <= wr_txd & ctrl_q[CTRL_SPE] & ~busy_i & ~start_q;
		end
	end

	// transmit and receive bytes
	always_ff @(posedge wb_clk_i) begin
		if (wr_txd && !busy_i)
			tx_q <= wb_dat_i; // engine copies it on start
		if (done_i)
			rx_q <= rx_data_i;
	end

	// ----------------------------------------
	// read side
	// ----------------------------------------

	always_comb begin
		stat_v            = '0;
		stat_v[STAT_TIP]  = busy_i;
		stat_v[STAT_DONE] = done_q;
	end

	always_comb begin
		case (wb_adr_i)
			REG_CTRL: wb_dat_o = {3'b000, ctrl_q};
			REG_STAT: wb_dat_o = stat_v;
			REG_DIVL: wb_dat_o = div_q[7:0];
			REG_DIVH: wb_dat_o = div_q[15:8];
			REG_TXD:  wb_dat_o = tx_q;
			REG_RXD:  wb_dat_o = rx_q;
			REG_SS:   wb_dat_o = 8'(ss_q);
			default:  wb_dat_o = 8'h00; // unmapped
		endcase
	end

	assign wb_ack_o  = ack_q;
	assign wb_inta_o = done_q & ctrl_q[CTRL_IE];
	assign start_o   = start_q;
	assign cpol_o    = ctrl_q[CTRL_CPOL];
	assign cpha_o    = ctrl_q[CTRL_CPHA];
	assign lsbfe_o   = ctrl_q[CTRL_LSBFE];
	assign divisor_o = DIV_W'(div_q);
	assign tx_data_o = tx_q;
	assign ss_sel_o  = ss_q;

endmodule

//--- verilog/spi_pkg.sv
// spi master shared definitions, register map, engine states and bit positions

package spi_pkg;

	// ----------------------------------------
	// register map
	// ----------------------------------------

	// wishbone byte address of each register
	typedef enum logic [2:0] {
		REG_CTRL = 3'd0, // spe, cpol, cpha, lsbfe, ie
		REG_STAT = 3'd1, // tip, done
		REG_DIVL = 3'd2, // divisor bits 7..0
		REG_DIVH = 3'd3, // divisor bits 15..8
		REG_TXD  = 3'd4, // write starts a transfer
		REG_RXD  = 3'd5, // last received byte
		REG_SS   = 3'd6  // one-hot slave select
	} spi_reg_e;

	// ----------------------------------------
	// serial engine states
	// ----------------------------------------

	typedef enum logic [1:0] {
		ST_IDLE  = 2'd0, // no transfer
		ST_LEAD  = 2'd1, // waiting for leading sclk edge
		ST_TRAIL = 2'd2, // waiting for trailing sclk edge
		ST_DONE  = 2'd3  // one cycle of completion
	} spi_state_e;

	// control register bits
	localparam logic [2:0] CTRL_SPE   = 3'd0; // core enable
	localparam logic [2:0] CTRL_CPOL  = 3'd1; // idle level of sclk
	localparam logic [2:0] CTRL_CPHA  = 3'd2; // sample on trailing edge when set
	localparam logic [2:0] CTRL_LSBFE = 3'd3; // lsb first
	localparam logic [2:0] CTRL_IE    = 3'd4; // interrupt enable

	// status register bits
	localparam logic [2:0] STAT_TIP  = 3'd0; // read only
	localparam logic [2:0] STAT_DONE = 3'd1; // sticky, write 1 to clear

endpackage
